/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -sv -f compile.f --top-module tb_top -Mdir obj_dir
	./obj_dir/Vtb_top | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* compile.f */
hdl/mips_pkg.sv
hdl/data_bus_if.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/alu.sv
hdl/datapath.sv
hdl/mycpu_top.sv
dv/wb_checker.sv
dv/tb_top.sv

/* dv/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    localparam int n_rows = 24;
    // three cycles per row at most, plus reset and slack
    localparam int limit = n_rows * 3 + 8 + 20;
    localparam logic [1:0] k_wb    = 2'd0;
    localparam logic [1:0] k_none  = 2'd1;
    localparam logic [1:0] k_store = 2'd2;
    localparam logic [1:0] k_skip  = 2'd3;

    logic                 clk;
    logic                 rst_n;
    logic                 inst_sram_en;
    mips_pkg::rwen_t      inst_sram_wen;
    mips_pkg::word_t      inst_sram_addr;
    mips_pkg::word_t      inst_sram_wdata;
    mips_pkg::word_t      inst_sram_rdata;
    logic                 data_sram_en;
    mips_pkg::rwen_t      data_sram_wen;
    mips_pkg::word_t      data_sram_addr;
    mips_pkg::word_t      data_sram_wdata;
    mips_pkg::word_t      data_sram_rdata;
    mips_pkg::word_t      debug_wb_pc;
    mips_pkg::rwen_t      debug_wb_rf_wen;
    mips_pkg::creg_addr_t debug_wb_rf_wnum;
    mips_pkg::word_t      debug_wb_rf_wdata;

    logic [63:0]     names [n_rows];
    logic [1:0]      kinds [n_rows];
    mips_pkg::word_t instrs [n_rows];
    mips_pkg::word_t auxs [n_rows];
    mips_pkg::word_t vals [n_rows];
    mips_pkg::word_t imem [256];
    mips_pkg::word_t dmem [256];
    mips_pkg::word_t inst_q;
    mips_pkg::word_t data_q;
    logic            done;
    int              val_errs;
    int              other_errs;
    int              cycles;
    int              n;
    logic            timed_out;

    mycpu_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    wb_checker #(.n_rows(n_rows)) checker0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .names             (names),
        .kinds             (kinds),
        .auxs              (auxs),
        .vals              (vals),
        .done              (done),
        .val_errs          (val_errs),
        .other_errs        (other_errs)
    );

    always #2 clk = ~clk;

    function automatic mips_pkg::word_t xorshift32(input mips_pkg::word_t x);
        mips_pkg::word_t s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // data fill, every index bit feeds the seed
    function automatic mips_pkg::word_t fill_word(input mips_pkg::word_t idx);
        return xorshift32(xorshift32(32'd72 ^ (idx * 32'h9e37_79b9)));
    endfunction

    // instruction encoders
    function automatic mips_pkg::word_t enc_r(input int rs, input int rt, input int rd,
                                              input int sa, input logic [5:0] fn);
        return {mips_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic mips_pkg::word_t enc_i(input logic [5:0] op, input int rs,
                                              input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic mips_pkg::word_t enc_j(input mips_pkg::word_t target);
        return {mips_pkg::op_j, target[27:2]};
    endfunction

    task automatic add_row(input logic [63:0] name, input mips_pkg::word_t ins,
                           input logic [1:0] kind, input mips_pkg::word_t aux,
                           input mips_pkg::word_t val);
        names[n]  = name;
        instrs[n] = ins;
        kinds[n]  = kind;
        auxs[n]   = aux;
        vals[n]   = val;
        n++;
    endtask

    // sram models, request sampled at posedge, data out on the falling edge
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_q <= imem[inst_sram_addr[9:2]];
        end
        if (data_sram_en) begin
            if (data_sram_wen != '0) begin
                dmem[data_sram_addr[9:2]] <= data_sram_wdata;
            end else begin
                data_q <= dmem[data_sram_addr[9:2]];
            end
        end
    end

    always @(negedge clk) begin
        inst_sram_rdata <= inst_q;
        data_sram_rdata <= data_q;
    end

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        inst_q          = '0;
        data_q          = '0;
        cycles          = 0;
        timed_out       = 1'b0;
        n               = 0;
        // alu ops on values built with lui and ori
        add_row("lui", enc_i(mips_pkg::op_lui, 0, 1, 16'h1234), k_wb, 1, 32'h1234_0000);
        add_row("ori_r1", enc_i(mips_pkg::op_ori, 1, 1, 16'h5678), k_wb, 1, 32'h1234_5678);
        add_row("ori_r2", enc_i(mips_pkg::op_ori, 0, 2, 16'h00f0), k_wb, 2, 32'h0000_00f0);
        add_row("addu", enc_r(1, 2, 3, 0, mips_pkg::fn_addu), k_wb, 3, 32'h1234_5768);
        add_row("subu", enc_r(2, 1, 4, 0, mips_pkg::fn_subu), k_wb, 4, 32'hedcb_aa78);
        add_row("and", enc_r(1, 2, 5, 0, mips_pkg::fn_and), k_wb, 5, 32'h0000_0070);
        add_row("or", enc_r(1, 2, 6, 0, mips_pkg::fn_or), k_wb, 6, 32'h1234_56f8);
        add_row("xor", enc_r(1, 2, 7, 0, mips_pkg::fn_xor), k_wb, 7, 32'h1234_5688);
        // negative r4 is less than r2
        add_row("slt", enc_r(4, 2, 8, 0, mips_pkg::fn_slt), k_wb, 8, 32'h0000_0001);
        add_row("sll", enc_r(0, 2, 9, 4, mips_pkg::fn_sll), k_wb, 9, 32'h0000_0f00);
        add_row("addiu", enc_i(mips_pkg::op_addiu, 0, 10, 16'hfffe), k_wb, 10, 32'hffff_fffe);
        add_row("andi", enc_i(mips_pkg::op_andi, 10, 11, 16'hff00), k_wb, 11, 32'h0000_ff00);
        // write to $zero stays off the trace
        add_row("addiu_r0", enc_i(mips_pkg::op_addiu, 0, 0, 16'h0005), k_none, 0, 0);
        add_row("addu_r0", enc_r(0, 2, 12, 0, mips_pkg::fn_addu), k_wb, 12, 32'h0000_00f0);
        add_row("sw", enc_i(mips_pkg::op_sw, 0, 1, 16'h0040), k_store, 32'h40, 32'h1234_5678);
        add_row("lw_back", enc_i(mips_pkg::op_lw, 0, 13, 16'h0040), k_wb, 13, 32'h1234_5678);
        add_row("lw_fresh", enc_i(mips_pkg::op_lw, 0, 14, 16'h0080), k_wb, 14, fill_word(32));
        // no delay slot, so the taken branch drops the row behind it
        add_row("beq_take", enc_i(mips_pkg::op_beq, 1, 1, 16'h0001), k_none, 0, 0);
        add_row("beq_skip", enc_i(mips_pkg::op_addiu, 0, 15, 16'h0001), k_skip, 15, 1);
        add_row("bne_keep", enc_i(mips_pkg::op_bne, 1, 1, 16'h0001), k_none, 0, 0);
        // ori immediate with bit 15 set stays zero-extended
        add_row("bne_next", enc_i(mips_pkg::op_ori, 0, 16, 16'h8007), k_wb, 16, 32'h0000_8007);
        add_row("j_fwd", enc_j(mips_pkg::reset_pc + 32'd92), k_none, 0, 0);
        add_row("j_skip", enc_i(mips_pkg::op_addiu, 0, 17, 16'h0009), k_skip, 17, 9);
        add_row("j_target", enc_r(16, 12, 18, 0, mips_pkg::fn_addu), k_wb, 18, 32'h0000_80f7);
        // rest of imem is zero, which decodes as a nop
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = fill_word(32'(i));
        end
        for (int i = 0; i < n_rows; i++) begin
            imem[(mips_pkg::reset_pc[9:2] + 8'(i))] = instrs[i];
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        cycles = 8;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("timeout after %0d cycles with writebacks still missing", cycles);
            timed_out = 1'b1;
        end
        $display("value errors %0d, other errors %0d", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

/* dv/wb_checker.sv */
`timescale 1ns/1ps

module wb_checker #(
    parameter int n_rows = 1
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_sram_en,
    input  mips_pkg::rwen_t      inst_sram_wen,
    input  mips_pkg::word_t      inst_sram_addr,
    input  mips_pkg::word_t      inst_sram_wdata,
    input  logic                 data_sram_en,
    input  mips_pkg::rwen_t      data_sram_wen,
    input  mips_pkg::word_t      data_sram_addr,
    input  mips_pkg::word_t      data_sram_wdata,
    input  mips_pkg::word_t      debug_wb_pc,
    input  mips_pkg::rwen_t      debug_wb_rf_wen,
    input  mips_pkg::creg_addr_t debug_wb_rf_wnum,
    input  mips_pkg::word_t      debug_wb_rf_wdata,
    input  logic [63:0]          names [n_rows],
    input  logic [1:0]           kinds [n_rows],
    input  mips_pkg::word_t      auxs [n_rows],
    input  mips_pkg::word_t      vals [n_rows],
    output logic                 done,
    output int                   val_errs,
    output int                   other_errs
);
    // row kinds, must match the table in tb_top
    localparam logic [1:0] k_wb    = 2'd0;
    localparam logic [1:0] k_store = 2'd2;
    localparam logic [1:0] k_skip  = 2'd3;

    int   ptr;
    int   fetches;
    logic warm;
    logic wb_evt;
    logic st_evt;

    // next row that should show up on the ports
    function automatic int next_event(input int from);
        int k;
        k = from;
        while (k < n_rows && kinds[k] != k_wb && kinds[k] != k_store) begin
            k++;
        end
        return k;
    endfunction

    // every row that is not jumped over gets fetched once
    function automatic int count_fetched();
        int c;
        c = 0;
        for (int i = 0; i < n_rows; i++) begin
            if (kinds[i] != k_skip) begin
                c++;
            end
        end
        return c;
    endfunction

    task automatic check_val(input logic [63:0] name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %0s: expected %h actual %h", name, what, exp, act);
            val_errs++;
        end
    endtask

    initial begin
        done        = 1'b0;
        val_errs    = 0;
        other_errs  = 0;
        ptr         = 0;
        fetches     = 0;
        warm        = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            // first edge still sees x state out of the core
            if (warm && (inst_sram_en || data_sram_en || debug_wb_rf_wen != '0)) begin
                $display("core is active while reset is asserted");
                other_errs++;
            end
            warm = 1'b1;
        end else if (!done) begin
            if (inst_sram_en) begin
                if (fetches == 0) begin
                    check_val("fetch0", "addr", mips_pkg::reset_pc, inst_sram_addr);
                end
                // instruction port never writes
                check_val("fetch", "wen", 32'h0, {28'b0, inst_sram_wen});
                check_val("fetch", "wdata", 32'h0, inst_sram_wdata);
                fetches++;
            end
            wb_evt = (debug_wb_rf_wen != '0);
            st_evt = data_sram_en && (data_sram_wen != '0);
            if (wb_evt && st_evt) begin
                $display("writeback and store seen in the same cycle");
                other_errs++;
            end
            if (wb_evt || st_evt) begin
                ptr = next_event(ptr);
                if (ptr >= n_rows) begin
                    $display("extra writeback or store after the last table row");
                    other_errs++;
                end else if (wb_evt != (kinds[ptr] == k_wb)) begin
                    $display("row %0s expected a %0s but saw a %0s", names[ptr],
                             (kinds[ptr] == k_wb) ? "writeback" : "store",
                             wb_evt ? "writeback" : "store");
                    other_errs++;
                    ptr++;
                end else begin
                    // table row address doubles as the expected trace pc
                    if (wb_evt) begin
                        check_val(names[ptr], "wen", 32'hf, {28'b0, debug_wb_rf_wen});
                        check_val(names[ptr], "wnum", auxs[ptr], {27'b0, debug_wb_rf_wnum});
                        check_val(names[ptr], "wdata", vals[ptr], debug_wb_rf_wdata);
                        check_val(names[ptr], "pc", mips_pkg::reset_pc + 32'(4 * ptr),
                                  debug_wb_pc);
                    end else begin
                        check_val(names[ptr], "wen", 32'hf, {28'b0, data_sram_wen});
                        check_val(names[ptr], "addr", auxs[ptr], data_sram_addr);
                        check_val(names[ptr], "wdata", vals[ptr], data_sram_wdata);
                    end
                    ptr++;
                end
                if (next_event(ptr) >= n_rows) begin
                    done = 1'b1;
                    check_val("fetches", "count", 32'(count_fetched()), 32'(fetches));
                end
            end
        end
    end
endmodule

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    output mips_pkg::word_t   y,
    output logic              equal
);
    logic lt_signed;

    // slt compares as two's complement
    assign lt_signed = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mips_pkg::alu_add: y = a + b;
            mips_pkg::alu_sub: y = a - b;
            mips_pkg::alu_and: y = a & b;
            mips_pkg::alu_or:  y = a | b;
            mips_pkg::alu_xor: y = a ^ b;
            mips_pkg::alu_slt: y = {31'b0, lt_signed};
            // sll shifts rt, rs is ignored
            mips_pkg::alu_sll: y = b << shamt;
            // immediate into the upper half
            mips_pkg::alu_lui: y = {b[15:0], 16'h0000};
            default:           y = a + b;
        endcase
    end

    // beq/bne condition on rs vs rt
    assign equal = (a == b);
endmodule

/* hdl/data_bus_if.sv */
`timescale 1ns/1ps

// data memory request/response between core and top
interface data_bus_if;
    logic            en;
    mips_pkg::rwen_t wen;
    mips_pkg::word_t addr;
    mips_pkg::word_t wdata;
    // valid the cycle after a read request
    mips_pkg::word_t rdata;

    // core side issues requests
    modport master (
        output en,
        output wen,
        output addr,
        output wdata,
        input  rdata
    );

    // sram side, answers one cycle later
    modport slave (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        output rdata
    );
endinterface

/* hdl/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic               clk,
    input  logic               rst_n,
    output logic               inst_en,
    output mips_pkg::word_t    pc,
    input  mips_pkg::word_t    instr,
    data_bus_if.master         dbus,
    output mips_pkg::rf_w_t    rfwrite,
    output mips_pkg::word_t    wb_pc
);
    mips_pkg::state_t     state_q;
    mips_pkg::state_t     state_d;
    mips_pkg::word_t      pc_q;
    mips_pkg::word_t      pc_d;
    mips_pkg::word_t      pc_plus4;
    mips_pkg::word_t      br_target;
    mips_pkg::word_t      j_target;
    mips_pkg::ctrl_t      ctrl;
    mips_pkg::creg_addr_t rs;
    mips_pkg::creg_addr_t rt;
    mips_pkg::creg_addr_t dst;
    mips_pkg::word_t      rs_val;
    mips_pkg::word_t      rt_val;
    mips_pkg::word_t      imm_ext;
    mips_pkg::word_t      alu_b;
    mips_pkg::word_t      alu_y;
    logic                 alu_equal;
    logic                 in_exec;
    logic                 in_wb;
    logic                 br_taken;
    // load tracking for the wb state
    logic                 ld_valid_q;
    mips_pkg::creg_addr_t ld_dst_q;
    mips_pkg::word_t      ld_pc_q;

    decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rs_val),
        .rdata2 (rt_val),
        .wen    (rfwrite.wen),
        .waddr  (rfwrite.addr),
        .wdata  (rfwrite.wd)
    );

    alu u_alu (
        .op    (ctrl.alu_op),
        .a     (rs_val),
        .b     (alu_b),
        .shamt (instr[10:6]),
        .y     (alu_y),
        .equal (alu_equal)
    );

    assign in_exec = (state_q == mips_pkg::st_exec);
    assign in_wb   = (state_q == mips_pkg::st_wb);

    // fetch request, sram returns the word next cycle
    assign inst_en = (state_q == mips_pkg::st_fetch);
    assign pc      = pc_q;

    // instruction fields, only meaningful in exec
    assign rs      = instr[25:21];
    assign rt      = instr[20:16];
    assign dst     = ctrl.dst_rt ? instr[20:16] : instr[15:11];
    assign imm_ext = ctrl.zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign alu_b   = ctrl.use_imm ? imm_ext : rt_val;

    // next pc, no delay slot so a branch redirects the next fetch
    assign pc_plus4  = pc_q + 32'd4;
    assign br_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], instr[25:0], 2'b00};
    assign br_taken  = (ctrl.branch_eq && alu_equal) || (ctrl.branch_ne && !alu_equal);

    always_comb begin
        if (ctrl.jump) begin
            pc_d = j_target;
        end else if (br_taken) begin
            pc_d = br_target;
        end else begin
            pc_d = pc_plus4;
        end
    end

    always_comb begin
        case (state_q)
            mips_pkg::st_fetch: state_d = mips_pkg::st_exec;
            // loads need a third cycle for the sram data
            mips_pkg::st_exec:  state_d = ctrl.mem_read ? mips_pkg::st_wb : mips_pkg::st_fetch;
            default:            state_d = mips_pkg::st_fetch;
        endcase
    end

    // reset parks in wb with no load pending, so the first fetch follows
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= mips_pkg::st_wb;
            pc_q       <= mips_pkg::reset_pc;
            ld_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            ld_valid_q <= in_exec && ctrl.mem_read;
            if (in_exec) begin
                pc_q <= pc_d;
            end
        end
    end

    // destination and pc of the load, used one cycle later
    always_ff @(posedge clk) begin
        if (in_exec) begin
            ld_dst_q <= dst;
            ld_pc_q  <= pc_q;
        end
    end

    // data access issued in exec; lw goes out with wen clear
    assign dbus.en    = in_exec && (ctrl.mem_read || ctrl.mem_write);
    assign dbus.wen   = (in_exec && ctrl.mem_write) ? 4'hf : 4'h0;
    assign dbus.addr  = alu_y;
    assign dbus.wdata = rt_val;

    // alu results retire in exec, load data in wb
    always_comb begin
        rfwrite.wen  = 1'b0;
        rfwrite.addr = dst;
        rfwrite.wd   = alu_y;
        if (in_wb) begin
            rfwrite.wen  = ld_valid_q;
            rfwrite.addr = ld_dst_q;
            rfwrite.wd   = dbus.rdata;
        end else if (in_exec && ctrl.reg_write && !ctrl.mem_read) begin
            rfwrite.wen = 1'b1;
        end
    end

    // pc pairs with rfwrite for the debug trace
    assign wb_pc = in_wb ? ld_pc_q : pc_q;

    // a fetch cycle carries no data access and no register write
    assert property (@(posedge clk) disable iff (!rst_n)
        inst_en |-> (!dbus.en && !rfwrite.wen))
        else $error("datapath: fetch overlaps a data access or writeback");

    // a load read is answered in a cycle free of stores and fetches
    assert property (@(posedge clk) disable iff (!rst_n)
        (dbus.en && (dbus.wen == '0)) |=> (in_wb && (dbus.wen == '0) && !inst_en))
        else $error("datapath: load read overlaps another access");

    // branch and jump targets keep the pc word aligned
    assert property (@(posedge clk) disable iff (!rst_n)
        pc_q[1:0] == 2'b00)
        else $error("datapath: misaligned pc %h", pc_q);
endmodule

/* hdl/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  mips_pkg::word_t instr,
    output mips_pkg::ctrl_t ctrl
);
    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // all-zero record acts as a nop
        ctrl = '0;
        case (opcode)
            mips_pkg::op_rtype: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
                    mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
                    mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
                    mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
                    mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
                    mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
                    mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
                    // unsupported funct, drop the write
                    default:           ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::op_addiu: begin
                ctrl.alu_op    = mips_pkg::alu_add;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst_rt    = 1'b1;
            end
            mips_pkg::op_andi: begin
                ctrl.alu_op    = mips_pkg::alu_and;
                ctrl.use_imm   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst_rt    = 1'b1;
            end
            mips_pkg::op_ori: begin
                ctrl.alu_op    = mips_pkg::alu_or;
                ctrl.use_imm   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst_rt    = 1'b1;
            end
            mips_pkg::op_lui: begin
                ctrl.alu_op    = mips_pkg::alu_lui;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst_rt    = 1'b1;
            end
            mips_pkg::op_lw: begin
                // address is rs + simm, write happens in wb state
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.dst_rt    = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            mips_pkg::op_sw: begin
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            // compare rs against rt
            mips_pkg::op_beq: ctrl.branch_eq = 1'b1;
            mips_pkg::op_bne: ctrl.branch_ne = 1'b1;
            mips_pkg::op_j:   ctrl.jump      = 1'b1;
            default: begin
                ctrl = '0;
            end
        endcase
    end
endmodule

/* hdl/mips_pkg.sv */
package mips_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [3:0]  rwen_t;
    typedef logic [4:0]  creg_addr_t;

    // boot vector in kseg1
    localparam word_t reset_pc = 32'hbfc0_0000;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // funct field for r-type, instr[5:0]
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    // alu function select
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_t;

    // core sequencing, one instruction in flight
    typedef enum logic [1:0] {
        st_fetch,
        st_exec,
        st_wb
    } state_t;

    // decoded control record
    typedef struct packed {
        alu_op_t alu_op;
        // b operand from the extended immediate
        logic    use_imm;
        // andi/ori zero-extend, the rest sign-extend
        logic    zero_ext;
        logic    reg_write;
        // i-type writes rt instead of rd
        logic    dst_rt;
        logic    mem_read;
        logic    mem_write;
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    // register writeback record, also feeds the debug port
    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } rf_w_t;

endpackage

/* hdl/mycpu_top.sv */
`timescale 1ns/1ps

module mycpu_top (
    input  logic                 clk,
    input  logic                 rst_n,

    output logic                 inst_sram_en,
    output mips_pkg::rwen_t      inst_sram_wen,
    output mips_pkg::word_t      inst_sram_addr,
    output mips_pkg::word_t      inst_sram_wdata,
    input  mips_pkg::word_t      inst_sram_rdata,

    output logic                 data_sram_en,
    output mips_pkg::rwen_t      data_sram_wen,
    output mips_pkg::word_t      data_sram_addr,
    output mips_pkg::word_t      data_sram_wdata,
    input  mips_pkg::word_t      data_sram_rdata,

    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);
    mips_pkg::rf_w_t rfwrite;

    // the top plays the sram side of the data bus
    data_bus_if dbus ();

    datapath u_datapath (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst_en (inst_sram_en),
        .pc      (inst_sram_addr),
        .instr   (inst_sram_rdata),
        .dbus    (dbus.master),
        .rfwrite (rfwrite),
        .wb_pc   (debug_wb_pc)
    );

    // instruction port is read only
    assign inst_sram_wen   = '0;
    assign inst_sram_wdata = '0;

    assign data_sram_en    = dbus.en;
    assign data_sram_wen   = dbus.wen;
    assign data_sram_addr  = dbus.addr;
    assign data_sram_wdata = dbus.wdata;
    assign dbus.rdata      = data_sram_rdata;

    // writes to $zero are hidden from the trace
    assign debug_wb_rf_wen   = {4{rfwrite.wen && (rfwrite.addr != '0)}};
    assign debug_wb_rf_wnum  = rfwrite.addr;
    assign debug_wb_rf_wdata = rfwrite.wd;
endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                 clk,
    input  mips_pkg::creg_addr_t raddr1,
    input  mips_pkg::creg_addr_t raddr2,
    output mips_pkg::word_t      rdata1,
    output mips_pkg::word_t      rdata2,
    input  logic                 wen,
    input  mips_pkg::creg_addr_t waddr,
    input  mips_pkg::word_t      wdata
);
    mips_pkg::word_t regs [31:0];

    // writes land at the clock edge ending the cycle
    // $zero is cleared on every edge and never takes a write
    always_ff @(posedge clk) begin
        if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
        regs[0] <= '0;
    end

    // combinational read straight from the array
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // $zero reads zero even right after a write aimed at it
    assert property (@(posedge clk)
        (wen && (waddr == '0)) |=>
            ((raddr1 != '0) || (rdata1 == '0)) && ((raddr2 != '0) || (rdata2 == '0)))
        else $error("regfile: register 0 read back nonzero");
endmodule
